/* hdl/mem_pkg.sv */
package mem_pkg;

    // bus commands shared by every requester and the memory
    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_command_t;

    localparam int ADDR_BITS = 64;
    localparam int DATA_BITS = 64;

    // tag 0 means no tag, or a refused command
    localparam int TAG_BITS = 4;
    localparam int MEM_TAGS = 4;

    // cycles from load acceptance to its data tag on the memory bus
    localparam int MEM_LATENCY = 8;

    // 8-byte words, indexed by addr[10:3]
    localparam int STORE_WORDS = 256;
    localparam int INDEX_BITS = $clog2(STORE_WORDS);
    localparam int BYTE_OFFSET_BITS = 3;

    localparam int COUNT_BITS = $clog2(MEM_LATENCY);

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [COUNT_BITS-1:0] count_t;

    // stores are acknowledged with a fixed response, never used as a data tag
    localparam tag_t STORE_RESPONSE = tag_t'(1);

    // countdown start so data leaves MEM_LATENCY cycles after acceptance
    localparam count_t LOAD_COUNT = count_t'(MEM_LATENCY - 1);

    // command from a requester, or from the arbiter to memory
    typedef struct packed {
        bus_command_t command;
        addr_t        addr;
        data_t        data;
    } mem_req_t;

    // memory reply: acceptance response plus returning load data and tag
    typedef struct packed {
        tag_t  response;
        data_t data;
        tag_t  tag;
    } mem_resp_t;

endpackage

/* hdl/mem_store.sv */
module mem_store (
    input  logic            clock,
    input  logic            reset,
    input  logic            write_enable,
    input  mem_pkg::index_t write_index,
    input  mem_pkg::index_t read_index,
    input  mem_pkg::data_t  write_data,
    output mem_pkg::data_t  read_data,
    output logic            clearing
);

    mem_pkg::data_t words [mem_pkg::STORE_WORDS];

    mem_pkg::index_t clear_index;

    // walk every word once after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            clearing <= 1'b1;
            clear_index <= '0;
        end else if (clearing) begin
            clear_index <= clear_index + 1'b1;
            if (clear_index == mem_pkg::index_t'(mem_pkg::STORE_WORDS - 1)) begin
                clearing <= 1'b0;
            end
        end
    end

    // clearing owns the write port until it is done
    always_ff @(posedge clock) begin
        if (clearing) begin
            words[clear_index] <= '0;
        end else if (write_enable) begin
            words[write_index] <= write_data;
        end
    end

    // reads see zero until the array is initialized
    assign read_data = clearing ? '0 : words[read_index];

endmodule

/* hdl/mem_tag_tracker.sv */
module mem_tag_tracker (
    input  logic               clock,
    input  logic               reset,
    input  logic               clearing,
    input  mem_pkg::mem_req_t  mem_req,
    input  mem_pkg::data_t     read_data,
    output mem_pkg::mem_resp_t mem_resp,
    output logic               write_enable,
    output mem_pkg::index_t    write_index,
    output mem_pkg::index_t    read_index,
    output mem_pkg::data_t     write_data
);

    // one entry per usable tag
    typedef struct packed {
        logic            busy;
        mem_pkg::index_t index;
        mem_pkg::count_t count;
    } tag_entry_t;

    tag_entry_t entries [1:mem_pkg::MEM_TAGS];

    mem_pkg::tag_t grant_tag;
    mem_pkg::tag_t done_tag;
    mem_pkg::index_t req_index;
    logic load_accept;

    assign req_index = mem_req.addr[mem_pkg::BYTE_OFFSET_BITS +: mem_pkg::INDEX_BITS];

    // lowest free tag, 0 when all are in flight
    always_comb begin
        grant_tag = '0;
        for (int t = mem_pkg::MEM_TAGS; t >= 1; t--) begin
            if (!entries[t].busy) begin
                grant_tag = mem_pkg::tag_t'(t);
            end
        end
    end

    // loads are accepted one per cycle, so at most one countdown expires at a time
    always_comb begin
        done_tag = '0;
        for (int t = 1; t <= mem_pkg::MEM_TAGS; t++) begin
            if (entries[t].busy && entries[t].count == '0) begin
                done_tag = mem_pkg::tag_t'(t);
            end
        end
    end

    assign load_accept = !clearing && mem_req.command == mem_pkg::bus_load
                         && grant_tag != '0;

    // stores go straight to the array at the next edge
    assign write_enable = !clearing && mem_req.command == mem_pkg::bus_store;
    assign write_index = req_index;
    assign write_data = mem_req.data;

    // read at return time so later stores are seen
    assign read_index = (done_tag != '0) ? entries[done_tag].index : '0;

    always_comb begin
        mem_resp.response = '0;
        if (!clearing) begin
            if (mem_req.command == mem_pkg::bus_store) begin
                mem_resp.response = mem_pkg::STORE_RESPONSE;
            end else if (mem_req.command == mem_pkg::bus_load) begin
                mem_resp.response = grant_tag;
            end
        end
        mem_resp.tag = done_tag;
        mem_resp.data = (done_tag != '0) ? read_data : '0;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int t = 1; t <= mem_pkg::MEM_TAGS; t++) begin
                entries[t].busy <= 1'b0;
            end
        end else begin
            for (int t = 1; t <= mem_pkg::MEM_TAGS; t++) begin
                if (entries[t].busy) begin
                    entries[t].count <= entries[t].count - 1'b1;
                end
                // tag is free again once its data has gone out
                if (mem_pkg::tag_t'(t) == done_tag) begin
                    entries[t].busy <= 1'b0;
                end
                if (load_accept && mem_pkg::tag_t'(t) == grant_tag) begin
                    entries[t].busy <= 1'b1;
                    entries[t].index <= req_index;
                    entries[t].count <= mem_pkg::LOAD_COUNT;
                end
            end
        end
    end

endmodule

/* hdl/mem_arbiter.sv */
module mem_arbiter (
    input  logic               clock,
    input  logic               reset,
    input  mem_pkg::mem_req_t  imem_req,
    input  mem_pkg::mem_req_t  dmem_req,
    input  mem_pkg::mem_req_t  rmem_req,
    input  mem_pkg::mem_resp_t mem_resp,
    output mem_pkg::mem_req_t  mem_req,
    output mem_pkg::mem_resp_t imem_resp,
    output mem_pkg::mem_resp_t dmem_resp,
    output mem_pkg::tag_t      rmem_response
);

    typedef enum logic [1:0] {
        arb_idle,
        arb_imem,
        arb_dmem,
        arb_rmem
    } arb_state_t;

    arb_state_t state;
    arb_state_t next_state;

    logic imem_wants;
    logic dmem_wants;
    logic rmem_wants;
    logic accepted;

    assign imem_wants = imem_req.command != mem_pkg::bus_none;
    assign dmem_wants = dmem_req.command != mem_pkg::bus_none;
    assign rmem_wants = rmem_req.command != mem_pkg::bus_none;

    // any non-zero memory response means the command was taken
    assign accepted = mem_resp.response != '0;

    // forward the command of the requester being served
    always_comb begin
        mem_req = '0;
        mem_req.command = mem_pkg::bus_none;
        case (state)
            arb_imem: mem_req = imem_req;
            arb_dmem: mem_req = dmem_req;
            arb_rmem: mem_req = rmem_req;
            default: mem_req.command = mem_pkg::bus_none;
        endcase
    end

    // retire first, then the other cache path, never the same requester twice in a row
    always_comb begin
        next_state = state;
        case (state)
            arb_idle: begin
                if (rmem_wants) begin
                    next_state = arb_rmem;
                end else if (dmem_wants) begin
                    next_state = arb_dmem;
                end else if (imem_wants) begin
                    next_state = arb_imem;
                end
            end
            arb_imem: begin
                if (accepted || !imem_wants) begin
                    if (rmem_wants) begin
                        next_state = arb_rmem;
                    end else if (dmem_wants) begin
                        next_state = arb_dmem;
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            arb_dmem: begin
                if (accepted || !dmem_wants) begin
                    if (rmem_wants) begin
                        next_state = arb_rmem;
                    end else if (imem_wants) begin
                        next_state = arb_imem;
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            arb_rmem: begin
                // rmem still shows the accepted store this cycle
                if (accepted || !rmem_wants) begin
                    if (dmem_wants) begin
                        next_state = arb_dmem;
                    end else if (imem_wants) begin
                        next_state = arb_imem;
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            default: next_state = arb_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= arb_idle;
            imem_resp <= '0;
            dmem_resp <= '0;
            rmem_response <= '0;
        end else begin
            state <= next_state;

            // only the requester being served sees the response
            imem_resp.response <= (state == arb_imem) ? mem_resp.response : '0;
            dmem_resp.response <= (state == arb_dmem) ? mem_resp.response : '0;
            rmem_response <= (state == arb_rmem) ? mem_resp.response : '0;

            // load data broadcast to both cache paths
            imem_resp.data <= mem_resp.data;
            imem_resp.tag <= mem_resp.tag;
            dmem_resp.data <= mem_resp.data;
            dmem_resp.tag <= mem_resp.tag;
        end
    end

endmodule

/* hdl/mem_subsystem.sv */
module mem_subsystem (
    input  logic               clock,
    input  logic               reset,
    input  mem_pkg::mem_req_t  imem_req,
    input  mem_pkg::mem_req_t  dmem_req,
    input  mem_pkg::mem_req_t  rmem_req,
    output mem_pkg::mem_resp_t imem_resp,
    output mem_pkg::mem_resp_t dmem_resp,
    output mem_pkg::tag_t      rmem_response
);

    // arbiter to tracker
    mem_pkg::mem_req_t mem_req;
    mem_pkg::mem_resp_t mem_resp;

    // tracker to store
    logic write_enable;
    mem_pkg::index_t write_index;
    mem_pkg::index_t read_index;
    mem_pkg::data_t write_data;
    mem_pkg::data_t read_data;
    logic clearing;

    mem_arbiter arbiter_i (
        .clock         (clock),
        .reset         (reset),
        .imem_req      (imem_req),
        .dmem_req      (dmem_req),
        .rmem_req      (rmem_req),
        .mem_resp      (mem_resp),
        .mem_req       (mem_req),
        .imem_resp     (imem_resp),
        .dmem_resp     (dmem_resp),
        .rmem_response (rmem_response)
    );

    mem_tag_tracker tracker_i (
        .clock        (clock),
        .reset        (reset),
        .clearing     (clearing),
        .mem_req      (mem_req),
        .read_data    (read_data),
        .mem_resp     (mem_resp),
        .write_enable (write_enable),
        .write_index  (write_index),
        .read_index   (read_index),
        .write_data   (write_data)
    );

    mem_store store_i (
        .clock        (clock),
        .reset        (reset),
        .write_enable (write_enable),
        .write_index  (write_index),
        .read_index   (read_index),
        .write_data   (write_data),
        .read_data    (read_data),
        .clearing     (clearing)
    );

endmodule

/* bench/mem_tb_model.svh */
`ifndef MEM_TB_MODEL_SVH
`define MEM_TB_MODEL_SVH

// reference copy of the 16 words the requesters touch
mem_pkg::data_t model_words [16];

// loads in flight, indexed by tag
logic tag_busy [1:mem_pkg::MEM_TAGS];
logic [3:0] tag_word [1:mem_pkg::MEM_TAGS];
int tag_due [1:mem_pkg::MEM_TAGS];
int outstanding;

task automatic clear_model();
    for (int w = 0; w < 16; w++) begin
        model_words[w] = '0;
    end
    for (int t = 1; t <= mem_pkg::MEM_TAGS; t++) begin
        tag_busy[t] = 1'b0;
    end
    outstanding = 0;
endtask

task automatic apply_store(mem_pkg::mem_req_t r);
    model_words[r.addr[6:3]] = r.data;
endtask

task automatic record_load(mem_pkg::tag_t tag, mem_pkg::mem_req_t r, int now);
    assert (tag >= 1 && tag <= mem_pkg::MEM_TAGS)
        else bad_event("load response carries a tag outside the usable range");
    assert (outstanding < mem_pkg::MEM_TAGS)
        else bad_event("load accepted while every tag was already in flight");
    assert (!tag_busy[tag])
        else bad_event("tag handed out while still outstanding");
    tag_busy[tag] = 1'b1;
    tag_word[tag] = r.addr[6:3];
    // data follows the response by the memory latency
    tag_due[tag] = now + mem_pkg::MEM_LATENCY;
    outstanding++;
endtask

task automatic check_return(mem_pkg::tag_t tag, mem_pkg::data_t data, int now);
    assert (tag >= 1 && tag <= mem_pkg::MEM_TAGS && tag_busy[tag])
        else bad_event("data tag returned with no matching outstanding load");
    assert (now == tag_due[tag])
        else wrong_value("data tag cycle", 64'(tag_due[tag]), 64'(now));
    assert (data == model_words[tag_word[tag]])
        else wrong_value("imem_resp.data", model_words[tag_word[tag]], data);
    tag_busy[tag] = 1'b0;
    outstanding--;
endtask

`endif

/* bench/mem_subsystem_tb.sv */
module mem_subsystem_tb;

    localparam int NUM_REQUESTS = 2000;
    localparam int TIMEOUT_CYCLES = NUM_REQUESTS * (mem_pkg::MEM_LATENCY + 4) + 300;

    logic clock;
    logic reset;
    mem_pkg::mem_req_t req [3];
    mem_pkg::mem_resp_t imem_resp;
    mem_pkg::mem_resp_t dmem_resp;
    mem_pkg::tag_t rmem_response;

    int seed;
    int cycle;
    int issued;
    logic acked [3];
    logic after_reset;
    logic held_prev [3];
    logic rmem_first;
    logic drained;

    mem_subsystem dut_i (
        .clock         (clock),
        .reset         (reset),
        .imem_req      (req[0]),
        .dmem_req      (req[1]),
        .rmem_req      (req[2]),
        .imem_resp     (imem_resp),
        .dmem_resp     (dmem_resp),
        .rmem_response (rmem_response)
    );

    `include "mem_tb_model.svh"

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic wrong_value(string name, logic [63:0] expected, logic [63:0] actual);
        $display("[FAIL] time %0t %s expected %h got %h", $time, name, expected, actual);
        stop_run();
    endtask

    task automatic bad_event(string what);
        $display("error at time %0t: %s", $time, what);
        stop_run();
    endtask

    // imem loads, rmem stores, dmem does both, all within 16 words
    function automatic mem_pkg::mem_req_t make_request(int requester);
        mem_pkg::mem_req_t r;
        int word;
        int lo;
        int hi;
        word = $random(seed);
        lo = $random(seed);
        hi = $random(seed);
        r.command = mem_pkg::bus_load;
        if (requester == 2 || (requester == 1 && word[4])) begin
            r.command = mem_pkg::bus_store;
        end
        r.addr = mem_pkg::addr_t'(word[3:0]) << 3;
        r.data = {hi, lo};
        return r;
    endfunction

    function automatic logic coin();
        int r;
        r = $random(seed);
        return r[1:0] != 2'd0;
    endfunction

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // requesters hold their command until the negedge check saw a response
    always @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < 3; i++) begin
                if (req[i].command != mem_pkg::bus_none) begin
                    if (acked[i]) begin
                        acked[i] = 1'b0;
                        if (issued < NUM_REQUESTS && coin()) begin
                            req[i] <= make_request(i);
                            issued++;
                        end else begin
                            req[i] <= '0;
                        end
                    end
                end else if (issued < NUM_REQUESTS && coin()) begin
                    req[i] <= make_request(i);
                    issued++;
                end
            end
        end
    end

    always @(negedge clock) begin
        int active;
        logic went_idle;
        cycle++;
        assert (cycle < TIMEOUT_CYCLES)
            else bad_event("run did not finish before the cycle limit");
        if (reset || after_reset) begin
            assert (imem_resp == '0)
                else wrong_value("imem_resp", '0, 64'(imem_resp.response));
            assert (dmem_resp == '0)
                else wrong_value("dmem_resp", '0, 64'(dmem_resp.response));
            assert (rmem_response == '0)
                else wrong_value("rmem_response", '0, 64'(rmem_response));
            after_reset = reset;
        end else begin
            // returning data first, before this cycle's stores reach the model
            assert (imem_resp.tag == dmem_resp.tag)
                else wrong_value("dmem_resp.tag", 64'(imem_resp.tag), 64'(dmem_resp.tag));
            assert (imem_resp.data == dmem_resp.data)
                else wrong_value("dmem_resp.data", imem_resp.data, dmem_resp.data);
            if (imem_resp.tag != '0) begin
                check_return(imem_resp.tag, imem_resp.data, cycle);
            end

            active = 0;
            if (imem_resp.response != '0) begin
                active++;
            end
            if (dmem_resp.response != '0) begin
                active++;
            end
            if (rmem_response != '0) begin
                active++;
            end
            assert (active <= 1) else bad_event("more than one response port active");

            // once rmem is owed the bus, the next response must be its own
            if (rmem_first && active != 0) begin
                assert (rmem_response != '0)
                    else bad_event("retire store was passed over by the arbiter");
                rmem_first = 1'b0;
            end
            // arbiter idle when nobody but the requester just answered held a command
            went_idle = (imem_resp.response != '0 || !held_prev[0])
                        && (dmem_resp.response != '0 || !held_prev[1])
                        && (rmem_response != '0 || !held_prev[2]);
            if (req[2].command != mem_pkg::bus_none && rmem_response == '0) begin
                if (went_idle || (held_prev[2]
                        && (imem_resp.response != '0 || dmem_resp.response != '0))) begin
                    rmem_first = 1'b1;
                end
            end

            if (imem_resp.response != '0) begin
                assert (req[0].command == mem_pkg::bus_load)
                    else bad_event("imem got a response without holding a load");
                record_load(imem_resp.response, req[0], cycle);
                acked[0] = 1'b1;
            end
            if (dmem_resp.response != '0) begin
                assert (req[1].command != mem_pkg::bus_none)
                    else bad_event("dmem got a response without holding a command");
                if (req[1].command == mem_pkg::bus_store) begin
                    apply_store(req[1]);
                end else begin
                    record_load(dmem_resp.response, req[1], cycle);
                end
                acked[1] = 1'b1;
            end
            if (rmem_response != '0) begin
                assert (req[2].command == mem_pkg::bus_store)
                    else bad_event("rmem got a response without holding a store");
                apply_store(req[2]);
                acked[2] = 1'b1;
            end

            for (int i = 0; i < 3; i++) begin
                held_prev[i] = req[i].command != mem_pkg::bus_none;
            end
            // every request answered and every load returned
            drained = issued == NUM_REQUESTS && outstanding == 0
                      && !held_prev[0] && !held_prev[1] && !held_prev[2];
        end
    end

    initial begin
        seed = 74381;
        cycle = 0;
        issued = 0;
        after_reset = 1'b1;
        rmem_first = 1'b0;
        drained = 1'b0;
        reset = 1'b1;
        for (int i = 0; i < 3; i++) begin
            req[i] = '0;
            acked[i] = 1'b0;
            held_prev[i] = 1'b0;
        end
        clear_model();
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        while (!drained) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);
        $display("Everything OK");
        $finish;
    end

endmodule

/* mem_subsystem.f */
+incdir+bench
hdl/mem_pkg.sv
hdl/mem_store.sv
hdl/mem_tag_tracker.sv
hdl/mem_arbiter.sv
hdl/mem_subsystem.sv
bench/mem_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= mem_subsystem_tb
FILELIST ?= mem_subsystem.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
